// File: Bender.yml
package:
  name: csr_file

sources:
  - csr_pkg.sv
  - csr_write_decode.sv
  - csr_machine_regs.sv
  - csr_trap_ctrl.sv
  - csr_file.sv
  - target: test
    files:
      - tb_csr_file.sv

// File: csr_file.sv
// --------------------
// machine CSR file top, single-cycle access without handshake
// reads are combinational, writes land at the next edge
// --------------------
`default_nettype none

module csr_file import csr_pkg::*; #(
    parameter xlen_t MISA_VALUE  = 32'h4014_0100,
    parameter xlen_t MTVEC_RESET = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        write_enable,
    input  csr_funct3_t f3,
    input  csr_addr_t   address,
    input  xlen_t       write_data,
    input  xlen_t       current_pc,
    input  xlen_t       fetch_instr,
    input  xlen_t       branch_target,
    input  xlen_t       mem_addr,
    input  logic        timer_irq,
    input  logic        soft_irq,
    input  logic        ext_irq,
    input  logic        mret,
    input  logic        exception,
    input  exc_cause_t  exception_cause,
    output xlen_t       read_data,
    output xlen_t       mtvec,
    output xlen_t       mepc,
    output logic        trap
);

    // decode to bank
    xlen_t   write_value;
    csr_we_t csr_we;
    // bank to trap controller and back
    xlen_t   pending_irqs;
    logic    global_ie;
    xlen_t   mtval_now;
    xlen_t   trap_cause;
    xlen_t   trap_value;

    csr_write_decode u_write_decode (
        .stall        (stall),
        .write_enable (write_enable),
        .address      (address),
        .f3           (f3),
        .write_data   (write_data),
        .read_data    (read_data),
        .write_value  (write_value),
        .csr_we       (csr_we)
    );

    csr_machine_regs #(
        .MISA_VALUE  (MISA_VALUE),
        .MTVEC_RESET (MTVEC_RESET)
    ) u_machine_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .write_value  (write_value),
        .csr_we       (csr_we),
        .timer_irq    (timer_irq),
        .soft_irq     (soft_irq),
        .ext_irq      (ext_irq),
        .trap         (trap),
        .mret         (mret),
        .current_pc   (current_pc),
        .trap_cause   (trap_cause),
        .trap_value   (trap_value),
        .read_data    (read_data),
        .pending_irqs (pending_irqs),
        .global_ie    (global_ie),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .mtval_now    (mtval_now)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .pending_irqs    (pending_irqs),
        .global_ie       (global_ie),
        .exception       (exception),
        .mret            (mret),
        .exception_cause (exception_cause),
        .current_pc      (current_pc),
        .fetch_instr     (fetch_instr),
        .branch_target   (branch_target),
        .mem_addr        (mem_addr),
        .mtval_now       (mtval_now),
        .trap            (trap),
        .trap_cause      (trap_cause),
        .trap_value      (trap_value)
    );

endmodule

`default_nettype wire

// File: csr_machine_regs.sv
// --------------------
// machine CSR bank with combinational read mux
// trap beats any write, mret beats a write to mstatus
// misa is fixed by parameter, mcause changes only on a trap
// --------------------
`default_nettype none

module csr_machine_regs import csr_pkg::*; #(
    parameter xlen_t MISA_VALUE  = 32'h4014_0100,
    parameter xlen_t MTVEC_RESET = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst_n,
    input  csr_addr_t address,
    input  xlen_t     write_value,
    input  csr_we_t   csr_we,
    input  logic      timer_irq,
    input  logic      soft_irq,
    input  logic      ext_irq,
    input  logic      trap,
    input  logic      mret,
    input  xlen_t     current_pc,
    input  xlen_t     trap_cause,
    input  xlen_t     trap_value,
    output xlen_t     read_data,
    output xlen_t     pending_irqs,
    output logic      global_ie,
    output xlen_t     mtvec,
    output xlen_t     mepc,
    output xlen_t     mtval_now
);

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mip;
    xlen_t mcause;
    xlen_t mscratch;
    xlen_t mtval;
    xlen_t mip_next;

    // interrupt lines placed at their mip positions
    always_comb begin
        mip_next                = '0;
        mip_next[IRQ_SOFT_BIT]  = soft_irq;
        mip_next[IRQ_TIMER_BIT] = timer_irq;
        mip_next[IRQ_EXT_BIT]   = ext_irq;
    end

    // --------------------
    // register updates
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus  <= MSTATUS_RESET;
            mie      <= '0;
            mip      <= '0;
            mtvec    <= MTVEC_RESET;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
            mtval    <= '0;
        end else begin
            // one cycle behind the lines
            mip <= mip_next;

            // save MIE into MPIE and mask on entry
            if (trap) begin
                mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (mret) begin
                mstatus[MSTATUS_MIE_BIT] <= mstatus[MSTATUS_MPIE_BIT];
            end else if (csr_we[WE_MSTATUS]) begin
                mstatus <= write_value;
            end

            if (csr_we[WE_MIE]) begin
                mie <= write_value;
            end

            if (csr_we[WE_MTVEC]) begin
                mtvec <= write_value;
            end

            // pc of the trapping instruction
            if (trap) begin
                mepc <= current_pc;
            end else if (csr_we[WE_MEPC]) begin
                mepc <= write_value;
            end

            if (trap) begin
                mcause <= trap_cause;
            end

            if (csr_we[WE_MSCRATCH]) begin
                mscratch <= write_value;
            end

            // trap_value already holds mtval when no update applies
            if (trap) begin
                mtval <= trap_value;
            end else if (csr_we[WE_MTVAL]) begin
                mtval <= write_value;
            end
        end
    end

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        case (address)
            ADDR_MSTATUS:  read_data = mstatus;
            ADDR_MISA:     read_data = MISA_VALUE;
            ADDR_MIE:      read_data = mie;
            ADDR_MTVEC:    read_data = mtvec;
            ADDR_MSCRATCH: read_data = mscratch;
            ADDR_MEPC:     read_data = mepc;
            ADDR_MCAUSE:   read_data = mcause;
            ADDR_MTVAL:    read_data = mtval;
            ADDR_MIP:      read_data = mip;
            // unknown CSR
            default:       read_data = '0;
        endcase
    end

    // to the trap controller
    assign pending_irqs = mie & mip;
    assign global_ie    = mstatus[MSTATUS_MIE_BIT];
    assign mtval_now    = mtval;

    // core must not retire mret while a new trap is taken
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap && mret));

endmodule

`default_nettype wire

// File: csr_pkg.sv
// --------------------
// shared widths, CSR addresses, bit positions and cause codes
// machine mode only, no debug or custom CSRs
// --------------------
`default_nettype none

package csr_pkg;

    // --------------------
    // widths
    // --------------------
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  csr_funct3_t;
    // cause code without the interrupt flag
    typedef logic [30:0] exc_cause_t;
    // one strobe per writable CSR
    typedef logic [5:0]  csr_we_t;

    typedef enum logic {
        TRAP_IDLE,
        TRAP_ACTIVE
    } trap_state_t;

    // strobe positions inside csr_we_t
    localparam int unsigned WE_MSTATUS  = 0;
    localparam int unsigned WE_MIE      = 1;
    localparam int unsigned WE_MTVEC    = 2;
    localparam int unsigned WE_MEPC     = 3;
    localparam int unsigned WE_MSCRATCH = 4;
    localparam int unsigned WE_MTVAL    = 5;

    // --------------------
    // machine CSR addresses
    // --------------------
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t ADDR_MIP      = 12'h344;

    // mstatus interrupt enable bits
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    // MPP = machine
    localparam xlen_t MSTATUS_RESET = 32'h0000_1800;

    // same positions in mie and mip
    localparam int unsigned IRQ_SOFT_BIT  = 3;
    localparam int unsigned IRQ_TIMER_BIT = 7;
    localparam int unsigned IRQ_EXT_BIT   = 11;

    // --------------------
    // cause codes
    // --------------------
    localparam exc_cause_t CAUSE_MISALIGNED_JUMP  = 31'd0;
    localparam exc_cause_t CAUSE_ILLEGAL_INSTR    = 31'd2;
    localparam exc_cause_t CAUSE_BREAKPOINT       = 31'd3;
    localparam exc_cause_t CAUSE_MISALIGNED_LOAD  = 31'd4;
    localparam exc_cause_t CAUSE_MISALIGNED_STORE = 31'd6;
    localparam exc_cause_t CAUSE_ECALL_M          = 31'd11;

    localparam exc_cause_t CAUSE_IRQ_SOFT  = 31'd3;
    localparam exc_cause_t CAUSE_IRQ_TIMER = 31'd7;
    localparam exc_cause_t CAUSE_IRQ_EXT   = 31'd11;

endpackage

`default_nettype wire

// File: csr_trap_ctrl.sv
// --------------------
// trap decision and mcause / mtval selection
// one trap at a time, cleared only by mret
// any pending interrupt wins the cause over an exception
// --------------------
`default_nettype none

module csr_trap_ctrl import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  xlen_t      pending_irqs,
    input  logic       global_ie,
    input  logic       exception,
    input  logic       mret,
    input  exc_cause_t exception_cause,
    input  xlen_t      current_pc,
    input  xlen_t      fetch_instr,
    input  xlen_t      branch_target,
    input  xlen_t      mem_addr,
    input  xlen_t      mtval_now,
    output logic       trap,
    output xlen_t      trap_cause,
    output xlen_t      trap_value
);

    trap_state_t state;
    logic        irq_pending;

    assign irq_pending = |pending_irqs;

    // --------------------
    // trap-taken state
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= TRAP_IDLE;
        end else if (trap) begin
            state <= TRAP_ACTIVE;
        end else if (mret) begin
            state <= TRAP_IDLE;
        end
    end

    // enabled interrupt or exception, only when idle
    assign trap = ((irq_pending && global_ie) || exception) && (state == TRAP_IDLE);

    // --------------------
    // mcause encode
    // --------------------
    always_comb begin
        trap_cause = '0;
        if (irq_pending) begin
            trap_cause[31] = 1'b1;
            // order sets priority: ext, timer, soft
            if (pending_irqs[IRQ_EXT_BIT]) begin
                trap_cause[30:0] = CAUSE_IRQ_EXT;
            end else if (pending_irqs[IRQ_TIMER_BIT]) begin
                trap_cause[30:0] = CAUSE_IRQ_TIMER;
            end else if (pending_irqs[IRQ_SOFT_BIT]) begin
                trap_cause[30:0] = CAUSE_IRQ_SOFT;
            end
        end else begin
            trap_cause[30:0] = exception_cause;
        end
    end

    // --------------------
    // mtval select
    // --------------------
    always_comb begin
        trap_value = mtval_now;
        if (exception) begin
            case (exception_cause)
                CAUSE_MISALIGNED_JUMP:  trap_value = branch_target;
                CAUSE_ILLEGAL_INSTR:    trap_value = fetch_instr;
                CAUSE_BREAKPOINT:       trap_value = current_pc;
                CAUSE_MISALIGNED_LOAD,
                CAUSE_MISALIGNED_STORE: trap_value = mem_addr;
                CAUSE_ECALL_M:          trap_value = '0;
                // other causes keep mtval
                default:                trap_value = mtval_now;
            endcase
        end
    end

    // a taken trap blocks further traps until mret
    a_no_nested_trap: assert property (@(posedge clk) disable iff (!rst_n)
        trap && !mret |=> !trap until_with mret);

endmodule

`default_nettype wire

// File: csr_write_decode.sv
// --------------------
// write value and strobe decode, purely combinational
// stall blocks every CSR write here and nowhere else
// misa, mcause and mip get no strobe
// --------------------
`default_nettype none

module csr_write_decode import csr_pkg::*; (
    input  logic        stall,
    input  logic        write_enable,
    input  csr_addr_t   address,
    input  csr_funct3_t f3,
    input  xlen_t       write_data,
    input  xlen_t       read_data,
    output xlen_t       write_value,
    output csr_we_t     csr_we
);

    logic write_ok;

    // --------------------
    // value by access kind
    // --------------------
    always_comb begin
        case (f3)
            // csrrw / csrrwi
            3'b001, 3'b101: write_value = write_data;
            // csrrs / csrrsi
            3'b010, 3'b110: write_value = read_data | write_data;
            // csrrc / csrrci
            3'b011, 3'b111: write_value = read_data & ~write_data;
            default:        write_value = '0;
        endcase
    end

    // no write while the core holds
    assign write_ok = write_enable && !stall;

    // --------------------
    // address to strobe
    // --------------------
    always_comb begin
        csr_we = '0;
        if (write_ok) begin
            case (address)
                ADDR_MSTATUS:  csr_we[WE_MSTATUS]  = 1'b1;
                ADDR_MIE:      csr_we[WE_MIE]      = 1'b1;
                ADDR_MTVEC:    csr_we[WE_MTVEC]    = 1'b1;
                ADDR_MEPC:     csr_we[WE_MEPC]     = 1'b1;
                ADDR_MSCRATCH: csr_we[WE_MSCRATCH] = 1'b1;
                ADDR_MTVAL:    csr_we[WE_MTVAL]    = 1'b1;
                // read-only or unknown
                default:       csr_we = '0;
            endcase
        end
    end

    // at most one register written per access
    always_comb begin
        a_we_onehot: assert final ($onehot0(csr_we));
    end

endmodule

`default_nettype wire

// File: sources.f
csr_pkg.sv
csr_write_decode.sv
csr_machine_regs.sv
csr_trap_ctrl.sv
csr_file.sv
tb_csr_file.sv

// File: tb_csr_file.sv
// --------------------
// directed testbench for the machine CSR file, default parameters
// inputs change on the rising edge, outputs are sampled on the falling edge
// --------------------
`default_nettype none

module tb_csr_file;

    // default parameter values and CSR addresses
    localparam logic [31:0] MISA_EXP    = 32'h4014_0100;
    localparam logic [31:0] MSTATUS_EXP = 32'h0000_1800;
    localparam logic [11:0] A_MSTATUS   = 12'h300;
    localparam logic [11:0] A_MISA      = 12'h301;
    localparam logic [11:0] A_MIE       = 12'h304;
    localparam logic [11:0] A_MTVEC     = 12'h305;
    localparam logic [11:0] A_MSCRATCH  = 12'h340;
    localparam logic [11:0] A_MEPC      = 12'h341;
    localparam logic [11:0] A_MCAUSE    = 12'h342;
    localparam logic [11:0] A_MTVAL     = 12'h343;
    localparam logic [11:0] A_MIP       = 12'h344;
    // reset, reset values, write kinds, six exceptions, irq priority, masked
    localparam int TEST_CYCLES = 16 + 8 + 24 + 6 * 11 + 16 + 20;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        write_enable;
    logic [2:0]  f3;
    logic [11:0] address;
    logic [31:0] write_data;
    logic [31:0] current_pc;
    logic [31:0] fetch_instr;
    logic [31:0] branch_target;
    logic [31:0] mem_addr;
    logic        timer_irq;
    logic        soft_irq;
    logic        ext_irq;
    logic        mret;
    logic        exception;
    logic [30:0] exception_cause;
    logic [31:0] read_data;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic        trap;
    int          errors = 0;
    logic [31:0] lcg_state = 32'hf460;

    csr_file dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .write_enable    (write_enable),
        .f3              (f3),
        .address         (address),
        .write_data      (write_data),
        .current_pc      (current_pc),
        .fetch_instr     (fetch_instr),
        .branch_target   (branch_target),
        .mem_addr        (mem_addr),
        .timer_irq       (timer_irq),
        .soft_irq        (soft_irq),
        .ext_irq         (ext_irq),
        .mret            (mret),
        .exception       (exception),
        .exception_cause (exception_cause),
        .read_data       (read_data),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .trap            (trap)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    // address on the edge, value read mid-cycle
    task automatic expect_csr(input string name, input logic [11:0] addr, input logic [31:0] exp);
        @(posedge clk);
        address <= addr;
        @(negedge clk);
        check_value(name, exp, read_data);
    endtask

    // one cycle access, lands on the following edge
    task automatic write_csr(input logic [11:0] addr, input logic [2:0] kind,
                             input logic [31:0] data, input logic hold);
        @(posedge clk);
        address      <= addr;
        f3           <= kind;
        write_data   <= data;
        write_enable <= 1'b1;
        stall        <= hold;
        @(posedge clk);
        write_enable <= 1'b0;
        stall        <= 1'b0;
    endtask

    // polls trap on falling edges, up to limit cycles
    task automatic wait_trap(input int limit, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            seen = trap;
        end
    endtask

    task automatic pulse_mret();
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
    endtask

    // mtval rule per exception cause
    function automatic logic [31:0] mtval_for(input logic [30:0] cause, input logic [31:0] old);
        case (cause)
            31'd0:        return branch_target;
            31'd2:        return fetch_instr;
            31'd3:        return current_pc;
            31'd4, 31'd6: return mem_addr;
            31'd11:       return 32'h0;
            default:      return old;
        endcase
    endfunction

    // --------------------
    // tests
    // --------------------
    task automatic test_reset();
        expect_csr("reset_misa", A_MISA, MISA_EXP);
        expect_csr("reset_mstatus", A_MSTATUS, MSTATUS_EXP);
        expect_csr("reset_mie", A_MIE, 32'h0);
        expect_csr("reset_mtvec", A_MTVEC, 32'h0);
        expect_csr("reset_mepc", A_MEPC, 32'h0);
        expect_csr("reset_mcause", A_MCAUSE, 32'h0);
        expect_csr("reset_mscratch", A_MSCRATCH, 32'h0);
        expect_csr("reset_mtval", A_MTVAL, 32'h0);
        check_value("reset_trap", 32'h0, trap);
        check_value("reset_mtvec_port", 32'h0, mtvec);
    endtask

    task automatic test_write_kinds();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = next_rand();
        b = next_rand();
        c = next_rand();
        write_csr(A_MSCRATCH, 3'b001, a, 1'b0);
        expect_csr("write_plain", A_MSCRATCH, a);
        write_csr(A_MSCRATCH, 3'b010, b, 1'b0);
        expect_csr("write_set", A_MSCRATCH, a | b);
        write_csr(A_MSCRATCH, 3'b011, c, 1'b0);
        expect_csr("write_clear", A_MSCRATCH, (a | b) & ~c);
        // reserved kind yields zero
        write_csr(A_MSCRATCH, 3'b000, next_rand(), 1'b0);
        expect_csr("write_f3_000", A_MSCRATCH, 32'h0);
        write_csr(A_MSCRATCH, 3'b101, a, 1'b0);
        write_csr(A_MSCRATCH, 3'b001, b, 1'b1);
        expect_csr("write_stall", A_MSCRATCH, a);
        // trap vector also leaves on its own port
        write_csr(A_MTVEC, 3'b001, c, 1'b0);
        expect_csr("write_mtvec", A_MTVEC, c);
        check_value("mtvec_port", c, mtvec);
        write_csr(A_MISA, 3'b001, c, 1'b0);
        expect_csr("write_misa", A_MISA, MISA_EXP);
        expect_csr("read_unknown", 12'h7c0, 32'h0);
    endtask

    task automatic test_exceptions();
        logic [30:0] causes [6];
        logic [31:0] old_mtval;
        logic [31:0] exp_mtval;
        causes = '{31'd0, 31'd2, 31'd3, 31'd4, 31'd6, 31'd11};
        old_mtval = 32'h0;
        foreach (causes[i]) begin
            // enable interrupts so MPIE capture is visible
            write_csr(A_MSTATUS, 3'b010, 32'h8, 1'b0);
            @(posedge clk);
            exception       <= 1'b1;
            exception_cause <= causes[i];
            current_pc      <= next_rand();
            fetch_instr     <= next_rand();
            branch_target   <= next_rand();
            mem_addr        <= next_rand();
            @(negedge clk);
            check_value("exc_trap", 32'h1, trap);
            exp_mtval = mtval_for(causes[i], old_mtval);
            old_mtval = exp_mtval;
            @(posedge clk);
            exception <= 1'b0;
            @(negedge clk);
            check_value("exc_mepc", current_pc, mepc);
            expect_csr("exc_mcause", A_MCAUSE, {1'b0, causes[i]});
            expect_csr("exc_mtval", A_MTVAL, exp_mtval);
            @(posedge clk);
            address <= A_MSTATUS;
            @(negedge clk);
            check_value("exc_mstatus_ie", 32'h80, read_data & 32'h88);
            // nested exception must be ignored
            @(posedge clk);
            exception <= 1'b1;
            @(negedge clk);
            check_value("exc_nested", 32'h0, trap);
            @(posedge clk);
            exception <= 1'b0;
            pulse_mret();
            @(negedge clk);
            check_value("mret_mie", 32'h8, read_data & 32'h8);
        end
    endtask

    task automatic test_irq_priority();
        logic seen;
        write_csr(A_MIE, 3'b001, 32'h888, 1'b0);
        write_csr(A_MSTATUS, 3'b010, 32'h8, 1'b0);
        @(posedge clk);
        timer_irq <= 1'b1;
        ext_irq   <= 1'b1;
        wait_trap(2, seen);
        check_value("irq_trap", 32'h1, seen);
        expect_csr("irq_mcause", A_MCAUSE, 32'h8000_000b);
        expect_csr("irq_mip", A_MIP, 32'h880);
        @(posedge clk);
        timer_irq <= 1'b0;
        ext_irq   <= 1'b0;
        // let mip drain before leaving the handler
        repeat (2) @(posedge clk);
        pulse_mret();
        write_csr(A_MIE, 3'b001, 32'h0, 1'b0);
    endtask

    task automatic test_masked();
        logic seen;
        // global enable off, mie on
        write_csr(A_MSTATUS, 3'b011, 32'h8, 1'b0);
        write_csr(A_MIE, 3'b001, 32'h888, 1'b0);
        @(posedge clk);
        soft_irq <= 1'b1;
        wait_trap(3, seen);
        check_value("mask_global_trap", 32'h0, seen);
        expect_csr("mask_global_mip", A_MIP, 32'h8);
        @(posedge clk);
        soft_irq <= 1'b0;
        // mie off, global enable on
        write_csr(A_MIE, 3'b001, 32'h0, 1'b0);
        write_csr(A_MSTATUS, 3'b010, 32'h8, 1'b0);
        @(posedge clk);
        timer_irq <= 1'b1;
        wait_trap(3, seen);
        check_value("mask_mie_trap", 32'h0, seen);
        expect_csr("mask_mie_mip", A_MIP, 32'h80);
        @(posedge clk);
        timer_irq <= 1'b0;
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial begin
        #(TEST_CYCLES * 2 * 20);
        $display("timeout after %0d cycles, tests did not finish", TEST_CYCLES * 2);
        $display("test failed");
        $finish;
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_n           = 1'b0;
        stall           = 1'b0;
        write_enable    = 1'b0;
        f3              = 3'b000;
        address         = 12'h0;
        write_data      = 32'h0;
        current_pc      = 32'h0;
        fetch_instr     = 32'h0;
        branch_target   = 32'h0;
        mem_addr        = 32'h0;
        timer_irq       = 1'b0;
        soft_irq        = 1'b0;
        ext_irq         = 1'b0;
        mret            = 1'b0;
        exception       = 1'b0;
        exception_cause = 31'h0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_write_kinds();
        test_exceptions();
        test_irq_priority();
        test_masked();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
